// ==== rtl/gn_defs.svh ====
`ifndef GN_DEFS_SVH
`define GN_DEFS_SVH

// Group geometry
`define GN_LANES        4
`define GN_GROUP_BEATS  4
`define GN_GROUP_SHIFT  4

// Fixed-point formats
`define GN_IN_WIDTH     8
`define GN_OUT_WIDTH    8
`define GN_OUT_FRAC     5
`define GN_RECIP_FRAC   12

// Sink credits held by the top level after reset
`define GN_OUT_CREDITS  2

`endif

// ==== rtl/gn_pkg.sv ====
`default_nettype none

`include "gn_defs.svh"

package gn_pkg;

    // Derived widths
    localparam int sum_width    = `GN_IN_WIDTH + `GN_GROUP_SHIFT;
    localparam int diff_width   = `GN_IN_WIDTH + 1;
    localparam int sq_sum_width = 2 * diff_width + `GN_GROUP_SHIFT;
    localparam int root_width   = sq_sum_width / 2;
    localparam int recip_width  = `GN_RECIP_FRAC + 1;

    // Depth of the scale stage FIFO
    localparam int norm_depth = 2;

    // Signed lane types, so that lane selects stay signed
    typedef logic signed [`GN_IN_WIDTH-1:0]  in_lane_t;
    typedef logic signed [diff_width-1:0]    diff_lane_t;
    typedef logic signed [`GN_OUT_WIDTH-1:0] out_lane_t;

    typedef struct packed {
        in_lane_t [`GN_LANES-1:0] lanes;
        logic                     last;
    } in_beat_t;

    typedef struct packed {
        diff_lane_t [`GN_LANES-1:0] lanes;
        logic                       last;
    } diff_beat_t;

    typedef struct packed {
        diff_lane_t [`GN_LANES-1:0] lanes;
        logic [recip_width-1:0]     recip;
        logic                       last;
    } norm_beat_t;

    typedef struct packed {
        out_lane_t [`GN_LANES-1:0] lanes;
        logic                      last;
    } out_beat_t;

endpackage

`default_nettype wire

// ==== rtl/gn_credit_fifo.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "gn_defs.svh"

module gn_credit_fifo #(
    parameter type payload_t = logic,
    parameter int  depth     = `GN_GROUP_BEATS
) (
    input  wire logic     clk,
    input  wire logic     rst_n,
    input  wire logic     push,
    input  wire payload_t push_data,
    input  wire logic     pop,
    output payload_t      pop_data,
    output logic          not_empty,
    output logic          credit
);
    localparam int ptr_width = (depth > 1) ? $clog2(depth) : 1;
    localparam logic [ptr_width-1:0] last_ptr = ptr_width'(depth - 1);

    payload_t             mem [depth];
    logic [ptr_width-1:0] wr_ptr;
    logic [ptr_width-1:0] rd_ptr;
    logic [ptr_width:0]   count;
    logic                 do_pop;

    assign do_pop    = pop && not_empty;
    assign not_empty = (count != '0);
    assign pop_data  = mem[rd_ptr];
    // Each freed entry goes straight back to the sender
    assign credit    = do_pop;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == last_ptr) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == last_ptr) ? '0 : rd_ptr + 1'b1;
            end
            if (push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/gn_mean_stage.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "gn_defs.svh"

module gn_mean_stage (
    input  wire logic             clk,
    input  wire logic             rst_n,
    input  wire logic             in_valid,
    input  wire gn_pkg::in_beat_t in_beat,
    input  wire logic             diff_credit,
    output logic                  in_credit,
    output logic                  diff_valid,
    output gn_pkg::diff_beat_t    diff_beat
);
    localparam int cnt_width = $clog2(`GN_GROUP_BEATS + 1);

    gn_pkg::in_beat_t                       pop_data;
    gn_pkg::diff_beat_t                     diff_next;
    gn_pkg::in_lane_t                       mean;
    logic signed [gn_pkg::sum_width-1:0]    sum_acc;
    logic signed [gn_pkg::sum_width-1:0]    beat_sum;
    logic signed [gn_pkg::sum_width-1:0]    sum_next;
    logic [cnt_width-1:0]                   diff_cnt;
    logic                                   not_empty;
    logic                                   replaying;
    logic                                   pop;

    gn_credit_fifo #(
        .payload_t (gn_pkg::in_beat_t),
        .depth     (`GN_GROUP_BEATS)
    ) u_in_fifo (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (in_valid),
        .push_data (in_beat),
        .pop       (pop),
        .pop_data  (pop_data),
        .not_empty (not_empty),
        .credit    (in_credit)
    );

    always_comb begin
        beat_sum = '0;
        for (int i = 0; i < `GN_LANES; i++) begin
            beat_sum = beat_sum + in_beat.lanes[i];
        end
        sum_next = sum_acc + beat_sum;
    end

    // One buffered beat per downstream credit
    assign pop = replaying && not_empty && (diff_cnt != '0);

    always_comb begin
        for (int i = 0; i < `GN_LANES; i++) begin
            diff_next.lanes[i] = pop_data.lanes[i] - mean;
        end
        diff_next.last = pop_data.last;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sum_acc    <= '0;
            replaying  <= 1'b0;
            diff_valid <= 1'b0;
            diff_cnt   <= cnt_width'(`GN_GROUP_BEATS);
        end else begin
            diff_valid <= pop;
            if (pop && pop_data.last) begin
                replaying <= 1'b0;
            end
            if (in_valid) begin
                if (in_beat.last) begin
                    sum_acc   <= '0;
                    replaying <= 1'b1;
                end else begin
                    sum_acc <= sum_next;
                end
            end
            case ({diff_credit, pop})
                2'b10:   diff_cnt <= diff_cnt + 1'b1;
                2'b01:   diff_cnt <= diff_cnt - 1'b1;
                default: diff_cnt <= diff_cnt;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        // Floor mean of the whole group
        if (in_valid && in_beat.last) begin
            mean <= gn_pkg::in_lane_t'(sum_next >>> `GN_GROUP_SHIFT);
        end
        if (pop) begin
            diff_beat <= diff_next;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/gn_isqrt.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "gn_defs.svh"

module gn_isqrt (
    input  wire logic                              clk,
    input  wire logic                              rst_n,
    input  wire logic                              start,
    input  wire logic [gn_pkg::sq_sum_width-1:0]   radicand,
    output logic                                   done,
    output logic [gn_pkg::root_width-1:0]          root
);
    localparam int w = gn_pkg::sq_sum_width;

    logic [w-1:0] op;
    logic [w-1:0] res;
    logic [w-1:0] one;
    logic [w-1:0] one_init;
    logic [w-1:0] trial;
    logic         busy;

    // Highest power of four not above the radicand, skips leading zero pairs
    always_comb begin
        one_init = '0;
        for (int k = 0; k < gn_pkg::root_width; k++) begin
            if (radicand[2*k +: 2] != 2'b00) begin
                one_init = w'(1) << (2 * k);
            end
        end
    end

    assign trial = res + one;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy <= 1'b0;
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start && !busy) begin
                busy <= 1'b1;
            end else if (busy && one == '0) begin
                busy <= 1'b0;
                done <= 1'b1;
            end
        end
    end

    // Restoring step, one result bit per cycle
    always_ff @(posedge clk) begin
        if (start && !busy) begin
            op  <= radicand;
            res <= '0;
            one <= one_init;
        end else if (busy) begin
            if (one == '0) begin
                root <= res[gn_pkg::root_width-1:0];
            end else begin
                if (op >= trial) begin
                    op  <= op - trial;
                    res <= (res >> 1) + one;
                end else begin
                    res <= res >> 1;
                end
                one <= one >> 2;
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/gn_var_stage.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "gn_defs.svh"

module gn_var_stage (
    input  wire logic               clk,
    input  wire logic               rst_n,
    input  wire logic               diff_valid,
    input  wire gn_pkg::diff_beat_t diff_beat,
    input  wire logic               norm_credit,
    output logic                    diff_credit,
    output logic                    norm_valid,
    output gn_pkg::norm_beat_t      norm_beat
);
    localparam int sq_w      = gn_pkg::sq_sum_width;
    localparam int cnt_width = $clog2(gn_pkg::norm_depth + 1);
    localparam logic [gn_pkg::recip_width-1:0] recip_one = 1 << `GN_RECIP_FRAC;

    typedef enum logic [1:0] {
        st_idle,
        st_wait,
        st_replay
    } state_t;

    state_t                                  state;
    gn_pkg::diff_beat_t                      pop_data;
    logic signed [2*gn_pkg::diff_width-1:0]  lane_sq;
    logic [sq_w-1:0]                         beat_sq;
    logic [sq_w-1:0]                         sq_acc;
    logic [sq_w-1:0]                         sq_next;
    logic [sq_w-1:0]                         radicand;
    logic [gn_pkg::root_width-1:0]           root;
    logic [gn_pkg::root_width-1:0]           root_safe;
    logic [gn_pkg::recip_width-1:0]          recip;
    logic [cnt_width-1:0]                    norm_cnt;
    logic                                    not_empty;
    logic                                    pop;
    logic                                    isqrt_start;
    logic                                    isqrt_done;

    gn_credit_fifo #(
        .payload_t (gn_pkg::diff_beat_t),
        .depth     (`GN_GROUP_BEATS)
    ) u_diff_fifo (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (diff_valid),
        .push_data (diff_beat),
        .pop       (pop),
        .pop_data  (pop_data),
        .not_empty (not_empty),
        .credit    (diff_credit)
    );

    gn_isqrt u_isqrt (
        .clk      (clk),
        .rst_n    (rst_n),
        .start    (isqrt_start),
        .radicand (radicand),
        .done     (isqrt_done),
        .root     (root)
    );

    // Squares are never negative, so the sum is kept unsigned
    always_comb begin
        beat_sq = '0;
        lane_sq = '0;
        for (int i = 0; i < `GN_LANES; i++) begin
            lane_sq = diff_beat.lanes[i] * diff_beat.lanes[i];
            beat_sq = beat_sq + sq_w'($unsigned(lane_sq));
        end
        sq_next = sq_acc + beat_sq;
    end

    // A zero root is treated as one
    assign root_safe = (root == '0) ? gn_pkg::root_width'(1) : root;
    assign pop = (state == st_replay) && not_empty && (norm_cnt != '0);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state       <= st_idle;
            sq_acc      <= '0;
            isqrt_start <= 1'b0;
            norm_valid  <= 1'b0;
            norm_cnt    <= cnt_width'(gn_pkg::norm_depth);
        end else begin
            isqrt_start <= 1'b0;
            norm_valid  <= pop;
            if (diff_valid) begin
                sq_acc <= diff_beat.last ? '0 : sq_next;
            end
            case (state)
                st_idle: begin
                    if (diff_valid && diff_beat.last) begin
                        isqrt_start <= 1'b1;
                        state       <= st_wait;
                    end
                end
                st_wait: begin
                    if (isqrt_done) begin
                        state <= st_replay;
                    end
                end
                default: begin
                    if (pop && pop_data.last) begin
                        state <= st_idle;
                    end
                end
            endcase
            case ({norm_credit, pop})
                2'b10:   norm_cnt <= norm_cnt + 1'b1;
                2'b01:   norm_cnt <= norm_cnt - 1'b1;
                default: norm_cnt <= norm_cnt;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (diff_valid && diff_beat.last) begin
            radicand <= sq_next >> `GN_GROUP_SHIFT;
        end
        if (isqrt_done) begin
            recip <= recip_one / root_safe;
        end
        if (pop) begin
            norm_beat.lanes <= pop_data.lanes;
            norm_beat.recip <= recip;
            norm_beat.last  <= pop_data.last;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/gn_scale_stage.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "gn_defs.svh"

module gn_scale_stage (
    input  wire logic               clk,
    input  wire logic               rst_n,
    input  wire logic               norm_valid,
    input  wire gn_pkg::norm_beat_t norm_beat,
    input  wire logic               out_credit,
    output logic                    norm_credit,
    output logic                    out_valid,
    output gn_pkg::out_beat_t       out_beat
);
    localparam int prod_width = gn_pkg::diff_width + gn_pkg::recip_width + 1;
    localparam int cnt_width  = $clog2(`GN_OUT_CREDITS + 1);
    localparam int out_max    = (1 << (`GN_OUT_WIDTH - 1)) - 1;
    localparam int out_min    = -(1 << (`GN_OUT_WIDTH - 1));

    gn_pkg::norm_beat_t              pop_data;
    gn_pkg::out_beat_t               out_next;
    logic signed [prod_width-1:0]    prod;
    logic signed [prod_width-1:0]    shifted;
    logic [cnt_width-1:0]            out_cnt;
    logic                            not_empty;
    logic                            pop;

    gn_credit_fifo #(
        .payload_t (gn_pkg::norm_beat_t),
        .depth     (gn_pkg::norm_depth)
    ) u_norm_fifo (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (norm_valid),
        .push_data (norm_beat),
        .pop       (pop),
        .pop_data  (pop_data),
        .not_empty (not_empty),
        .credit    (norm_credit)
    );

    assign pop = not_empty && (out_cnt != '0);

    always_comb begin
        prod    = '0;
        shifted = '0;
        for (int i = 0; i < `GN_LANES; i++) begin
            // Reciprocal is unsigned, zero-extend before the signed multiply
            prod    = pop_data.lanes[i] * $signed({1'b0, pop_data.recip});
            shifted = prod >>> (`GN_RECIP_FRAC - `GN_OUT_FRAC);
            if (shifted > out_max) begin
                out_next.lanes[i] = gn_pkg::out_lane_t'(out_max);
            end else if (shifted < out_min) begin
                out_next.lanes[i] = gn_pkg::out_lane_t'(out_min);
            end else begin
                out_next.lanes[i] = gn_pkg::out_lane_t'(shifted);
            end
        end
        out_next.last = pop_data.last;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            out_cnt   <= cnt_width'(`GN_OUT_CREDITS);
        end else begin
            out_valid <= pop;
            case ({out_credit, pop})
                2'b10:   out_cnt <= out_cnt + 1'b1;
                2'b01:   out_cnt <= out_cnt - 1'b1;
                default: out_cnt <= out_cnt;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            out_beat <= out_next;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/gn_top.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "gn_defs.svh"

module gn_top (
    input  wire logic             clk,
    input  wire logic             rst_n,
    input  wire logic             in_valid,
    input  wire gn_pkg::in_beat_t in_beat,
    input  wire logic             out_credit,
    output logic                  in_credit,
    output logic                  out_valid,
    output gn_pkg::out_beat_t     out_beat
);
    // Mean to variance link
    logic               diff_valid;
    gn_pkg::diff_beat_t diff_beat;
    logic               diff_credit;

    // Variance to scale link
    logic               norm_valid;
    gn_pkg::norm_beat_t norm_beat;
    logic               norm_credit;

    gn_mean_stage u_mean (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_valid    (in_valid),
        .in_beat     (in_beat),
        .diff_credit (diff_credit),
        .in_credit   (in_credit),
        .diff_valid  (diff_valid),
        .diff_beat   (diff_beat)
    );

    gn_var_stage u_var (
        .clk         (clk),
        .rst_n       (rst_n),
        .diff_valid  (diff_valid),
        .diff_beat   (diff_beat),
        .norm_credit (norm_credit),
        .diff_credit (diff_credit),
        .norm_valid  (norm_valid),
        .norm_beat   (norm_beat)
    );

    gn_scale_stage u_scale (
        .clk         (clk),
        .rst_n       (rst_n),
        .norm_valid  (norm_valid),
        .norm_beat   (norm_beat),
        .out_credit  (out_credit),
        .norm_credit (norm_credit),
        .out_valid   (out_valid),
        .out_beat    (out_beat)
    );

endmodule

`default_nettype wire

// ==== verif/gn_clock_gen.sv ====
`timescale 1ns/1ns
`default_nettype none

module gn_clock_gen #(
    parameter int period     = 40,
    parameter int rst_cycles = 2
) (
    output logic clk,
    output logic rst_n
);
    initial begin
        clk = 1'b0;
        forever begin
            #(period / 2);
            clk = ~clk;
        end
    end

    // Reset covers the first rising edges and releases just after one
    initial begin
        rst_n = 1'b0;
        repeat (rst_cycles) @(posedge clk);
        #1;
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire

// ==== verif/gn_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "gn_defs.svh"

module gn_tb;
    localparam int group_elems   = `GN_LANES * `GN_GROUP_BEATS;
    localparam int in_bits       = group_elems * `GN_IN_WIDTH;
    localparam int out_bits      = group_elems * `GN_OUT_WIDTH;
    localparam int out_max       = (1 << (`GN_OUT_WIDTH - 1)) - 1;
    localparam int out_min       = -(1 << (`GN_OUT_WIDTH - 1));
    localparam int n_random      = 20;
    localparam int n_saturation  = 4;
    localparam int n_backpress   = 4;
    localparam int n_flow        = 8;
    localparam int total_groups  = n_random + 1 + n_saturation + n_backpress + n_flow;
    localparam int timeout_limit = 200 + total_groups * (`GN_GROUP_BEATS * 6 + 40);
    localparam int hold_cycles   = 150;

    logic              clk;
    logic              rst_n;
    logic              in_valid;
    gn_pkg::in_beat_t  in_beat;
    logic              in_credit;
    logic              out_valid;
    gn_pkg::out_beat_t out_beat;
    logic              out_credit;

    gn_pkg::in_beat_t  send_q [$];
    gn_pkg::out_beat_t exp_q [$];
    gn_pkg::out_beat_t exp_beat;
    string             current_test = "reset";
    logic [15:0]       lfsr_state = 16'd49863;
    logic              sink_hold = 1'b0;
    int                src_credits = `GN_GROUP_BEATS;
    int                sent_total = 0;
    int                credit_total = 0;
    int                granted = `GN_OUT_CREDITS;
    int                received = 0;
    int                owed = 0;
    int                out_count = 0;
    int                cycle_count = 0;
    int                mismatch_errors = 0;
    int                other_errors = 0;

    gn_clock_gen #(.period(40), .rst_cycles(2)) u_clock (
        .clk   (clk),
        .rst_n (rst_n)
    );

    gn_top dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .in_beat    (in_beat),
        .out_credit (out_credit),
        .in_credit  (in_credit),
        .out_valid  (out_valid),
        .out_beat   (out_beat)
    );

    initial begin
        in_valid   = 1'b0;
        in_beat    = '0;
        out_credit = 1'b0;
    end

    // Galois LFSR, taps for a maximal 16-bit sequence
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    function automatic int random_bits(input int n);
        int val;
        val = 0;
        for (int b = 0; b < n; b++) begin
            lfsr_state = lfsr_next(lfsr_state);
            val = (val << 1) | int'(lfsr_state[0]);
        end
        return val;
    endfunction

    // Expected output lanes of one group, element e is beat e/LANES, lane e%LANES
    function automatic logic [out_bits-1:0] normalize_group(input logic [in_bits-1:0] grp);
        int x [group_elems];
        int sum;
        int mean;
        int sq_sum;
        int variance;
        int root;
        int recip;
        int scaled;
        logic [out_bits-1:0] res;
        sum    = 0;
        sq_sum = 0;
        for (int e = 0; e < group_elems; e++) begin
            x[e] = $signed(grp[e*`GN_IN_WIDTH +: `GN_IN_WIDTH]);
            sum += x[e];
        end
        // Floor division by the element count
        mean = (sum >= 0) ? sum / group_elems : -((-sum + group_elems - 1) / group_elems);
        for (int e = 0; e < group_elems; e++) begin
            sq_sum += (x[e] - mean) * (x[e] - mean);
        end
        variance = sq_sum / group_elems;
        root = 0;
        while ((root + 1) * (root + 1) <= variance) begin
            root++;
        end
        if (root == 0) begin
            root = 1;
        end
        recip = (1 << `GN_RECIP_FRAC) / root;
        for (int e = 0; e < group_elems; e++) begin
            scaled = ((x[e] - mean) * recip) >>> (`GN_RECIP_FRAC - `GN_OUT_FRAC);
            if (scaled > out_max) begin
                scaled = out_max;
            end else if (scaled < out_min) begin
                scaled = out_min;
            end
            res[e*`GN_OUT_WIDTH +: `GN_OUT_WIDTH] = scaled[`GN_OUT_WIDTH-1:0];
        end
        return res;
    endfunction

    function automatic logic [in_bits-1:0] random_group();
        logic [in_bits-1:0] grp;
        for (int e = 0; e < group_elems; e++) begin
            grp[e*`GN_IN_WIDTH +: `GN_IN_WIDTH] = random_bits(`GN_IN_WIDTH);
        end
        return grp;
    endfunction

    function automatic logic [in_bits-1:0] outlier_group(input int base, input int idx,
                                                         input int val);
        logic [in_bits-1:0] grp;
        for (int e = 0; e < group_elems; e++) begin
            grp[e*`GN_IN_WIDTH +: `GN_IN_WIDTH] = (e == idx) ? val : base;
        end
        return grp;
    endfunction

    function automatic logic [in_bits-1:0] alternating_group();
        logic [in_bits-1:0] grp;
        for (int e = 0; e < group_elems; e++) begin
            grp[e*`GN_IN_WIDTH +: `GN_IN_WIDTH] = (e % 2 == 0) ? 127 : -128;
        end
        return grp;
    endfunction

    task automatic add_group(input logic [in_bits-1:0] grp);
        gn_pkg::in_beat_t    beat;
        gn_pkg::out_beat_t   ob;
        logic [out_bits-1:0] norm;
        int                  e;
        norm = normalize_group(grp);
        for (int b = 0; b < `GN_GROUP_BEATS; b++) begin
            for (int l = 0; l < `GN_LANES; l++) begin
                e = b * `GN_LANES + l;
                beat.lanes[l] = grp[e*`GN_IN_WIDTH +: `GN_IN_WIDTH];
                ob.lanes[l]   = norm[e*`GN_OUT_WIDTH +: `GN_OUT_WIDTH];
            end
            beat.last = (b == `GN_GROUP_BEATS - 1);
            ob.last   = beat.last;
            send_q.push_back(beat);
            exp_q.push_back(ob);
        end
    endtask

    task automatic wait_drain();
        while (send_q.size() != 0 || exp_q.size() != 0) begin
            @(posedge clk);
        end
        repeat (4) @(posedge clk);
    endtask

    // Source sends under its credit count, a returned credit is usable next cycle
    always @(posedge clk) begin
        #1;
        in_valid = 1'b0;
        if (src_credits > 0 && send_q.size() > 0) begin
            in_beat     = send_q.pop_front();
            in_valid    = 1'b1;
            src_credits = src_credits - 1;
            sent_total  = sent_total + 1;
        end
        if (in_credit) begin
            src_credits  = src_credits + 1;
            credit_total = credit_total + 1;
            if (src_credits > `GN_GROUP_BEATS) begin
                other_errors++;
                $display("input credit returned with no beat outstanding");
            end
        end
    end

    // Sink hands back one credit per received beat unless it is holding
    always @(posedge clk) begin
        #1;
        if (out_valid) begin
            received = received + 1;
            owed     = owed + 1;
            if (received > granted) begin
                other_errors++;
                $display("sink received beat %0d with only %0d credits granted",
                         received, granted);
            end
        end
        out_credit = 1'b0;
        if (!sink_hold && owed > 0) begin
            out_credit = 1'b1;
            owed       = owed - 1;
            granted    = granted + 1;
        end
    end

    always @(posedge clk) begin
        #1;
        if (out_valid) begin
            if (exp_q.size() == 0) begin
                other_errors++;
                $display("output beat %0d arrived with no expected beat left", out_count);
            end else begin
                exp_beat = exp_q.pop_front();
                for (int l = 0; l < `GN_LANES; l++) begin
                    if (out_beat.lanes[l] !== exp_beat.lanes[l]) begin
                        mismatch_errors++;
                        $display("mismatch %s beat %0d lane %0d: expected %0d, actual %0d",
                                 current_test, out_count, l, exp_beat.lanes[l],
                                 out_beat.lanes[l]);
                    end
                end
                if (out_beat.last !== exp_beat.last) begin
                    mismatch_errors++;
                    $display("mismatch %s beat %0d last: expected %0b, actual %0b",
                             current_test, out_count, exp_beat.last, out_beat.last);
                end
            end
            if (out_beat.last !== (out_count % `GN_GROUP_BEATS == `GN_GROUP_BEATS - 1)) begin
                other_errors++;
                $display("last flag out of place on output beat %0d", out_count);
            end
            out_count = out_count + 1;
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= timeout_limit) begin
            $display("timeout: run did not finish within %0d cycles", timeout_limit);
            $display("Result: FAILED");
            $finish;
        end
    end

    initial begin
        wait (rst_n === 1'b1);
        @(posedge clk);

        current_test = "random";
        repeat (n_random) add_group(random_group());
        wait_drain();

        current_test = "constant";
        add_group(outlier_group(-77, 0, -77));
        wait_drain();

        // Single small outliers floor the root to one, which pushes lanes past the range
        current_test = "saturation";
        add_group(alternating_group());
        add_group(outlier_group(20, 5, 24));
        add_group(outlier_group(-30, 10, -36));
        add_group(outlier_group(100, group_elems - 1, 104));
        wait_drain();

        current_test = "backpressure";
        sink_hold = 1'b1;
        repeat (n_backpress) add_group(random_group());
        repeat (hold_cycles) @(posedge clk);
        if (exp_q.size() == 0) begin
            other_errors++;
            $display("output did not stall while the sink withheld credits");
        end
        sink_hold = 1'b0;
        wait_drain();

        current_test = "flow_control";
        repeat (n_flow) add_group(random_group());
        wait_drain();
        if (credit_total != sent_total) begin
            other_errors++;
            $display("input credits returned %0d, beats sent %0d", credit_total, sent_total);
        end
        if (src_credits != `GN_GROUP_BEATS || out_count != sent_total) begin
            other_errors++;
            $display("engine did not drain: %0d source credits, %0d of %0d beats out",
                     src_credits, out_count, sent_total);
        end

        $display("errors: %0d mismatches, %0d other failures", mismatch_errors, other_errors);
        if (mismatch_errors + other_errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+rtl
rtl/gn_pkg.sv
rtl/gn_credit_fifo.sv
rtl/gn_mean_stage.sv
rtl/gn_isqrt.sv
rtl/gn_var_stage.sv
rtl/gn_scale_stage.sv
rtl/gn_top.sv
verif/gn_clock_gen.sv
verif/gn_tb.sv

// ==== Bender.yml ====
package:
  name: gn_norm

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/gn_pkg.sv
      - rtl/gn_credit_fifo.sv
      - rtl/gn_mean_stage.sv
      - rtl/gn_isqrt.sv
      - rtl/gn_var_stage.sv
      - rtl/gn_scale_stage.sv
      - rtl/gn_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - verif/gn_clock_gen.sv
      - verif/gn_tb.sv
